// ==== Makefile ====
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := ball_video_tb
FLIST      := ball_video_top.f
OBJ_DIR    := obj_dir
RUN_ARGS   := +verilator+error+limit+1000000
PASS_MSG   := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== ball_video_top.f ====
logic/video_pkg.sv
logic/video_timing.sv
logic/ball_motion.sv
logic/draw_pipeline.sv
logic/ball_video_top.sv
bench/ball_video_assert.sv
bench/ball_video_tb.sv

// ==== bench/ball_video_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_video_assert (
        input logic        clk,
        input logic        reset,
        input logic        vsync,
        input logic        hsync,
        input logic        de,
        input logic [23:0] rgb,
        input logic        fs,
        input logic        le
);

        import video_pkg::*;

        logic        hsync_q;
        logic        vsync_q;
        logic        h_fall;
        logic        h_rise;
        logic        v_fall;
        logic        v_rise;
        logic        h_armed;
        logic        v_armed;
        logic        seen_de;
        logic        frame_has_de;
        logic        y_turn;
        logic [23:0] expect_rgb;
        int          startup_cnt;
        int          col_cnt;
        int          row_cnt;
        int          pix_x;
        int          pix_y;
        int          h_low_len;
        int          h_period;
        int          v_low_len;
        int          v_period;
        int          model_bx;
        int          model_by;
        int          model_dx;
        int          model_dy;
        int          dist_x;
        int          dist_y;
        int          y_flips;

        assign h_fall = hsync_q && !hsync;
        assign h_rise = !hsync_q && hsync;
        assign v_fall = vsync_q && !vsync;
        assign v_rise = !vsync_q && vsync;
        assign y_turn = v_fall && model_dy < 0 && model_by < ball_r;

        // pixel position rebuilt from the markers
        assign pix_x = fs ? 0 : col_cnt;
        assign pix_y = fs ? 0 : row_cnt;

        always_comb begin
                dist_x = pix_x - model_bx;
                dist_y = pix_y - model_by;
                if (dist_x * dist_x + dist_y * dist_y <= ball_r * ball_r) begin
                        expect_rgb = rgb_ball;
                end else if (pix_x % (1 << grid_shift) == 0 ||
                             pix_y % (1 << grid_shift) == 0) begin
                        expect_rgb = rgb_grid;
                end else begin
                        expect_rgb = rgb_bg;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        hsync_q      <= 1'b1;
                        vsync_q      <= 1'b1;
                        h_armed      <= 1'b0;
                        v_armed      <= 1'b0;
                        seen_de      <= 1'b0;
                        frame_has_de <= 1'b0;
                        startup_cnt  <= 0;
                        col_cnt      <= 0;
                        row_cnt      <= 0;
                        h_low_len    <= 0;
                        h_period     <= 0;
                        v_low_len    <= 0;
                        v_period     <= 0;
                        model_bx     <= h_active / 2;
                        model_by     <= v_active / 2;
                        model_dx     <= -1;
                        model_dy     <= -1;
                        y_flips      <= 0;
                end else begin
                        hsync_q   <= hsync;
                        vsync_q   <= vsync;
                        h_low_len <= hsync ? 0 : h_low_len + 1;
                        v_low_len <= vsync ? 0 : v_low_len + 1;
                        h_period  <= h_fall ? 1 : h_period + 1;
                        v_period  <= v_fall ? 1 : v_period + 1;
                        if (startup_cnt < 100) begin
                                startup_cnt <= startup_cnt + 1;
                        end
                        if (h_fall) begin
                                h_armed <= 1'b1;
                        end
                        if (de) begin
                                seen_de      <= 1'b1;
                                frame_has_de <= 1'b1;
                                if (le) begin
                                        col_cnt <= 0;
                                        row_cnt <= pix_y + 1;
                                end else begin
                                        col_cnt <= pix_x + 1;
                                        row_cnt <= pix_y;
                                end
                        end
                        // one ball step per displayed frame
                        if (v_fall) begin
                                v_armed      <= 1'b1;
                                frame_has_de <= 1'b0;
                                model_bx     <= model_bx + model_dx;
                                model_by     <= model_by + model_dy;
                                if ((model_bx < ball_r && model_dx < 0) ||
                                    (model_bx > h_active - ball_r && model_dx > 0)) begin
                                        model_dx <= -model_dx;
                                end
                                if ((model_by < ball_r && model_dy < 0) ||
                                    (model_by > v_active - ball_r && model_dy > 0)) begin
                                        model_dy <= -model_dy;
                                end
                                if (y_turn) begin
                                        y_flips <= y_flips + 1;
                                end
                        end
                end
        end

        // quiet outputs until the first pixel leaves 6 cycles after reset
        a_startup: assert property (@(posedge clk) disable iff (reset)
                !seen_de |-> (de == (startup_cnt == draw_stages + 1)) &&
                             (de || (hsync && vsync && !fs && !le)))
        else begin
                $error("MISMATCH at %0t: outputs wrong before first pixel, de %b cycle %0d",
                       $time, $sampled(de), $sampled(startup_cnt));
                ball_video_tb.error_count++;
        end

        a_marker_idle: assert property (@(posedge clk) disable iff (reset)
                !de |-> !fs && !le)
        else begin
                $error("MISMATCH at %0t: fs or le high outside de", $time);
                ball_video_tb.error_count++;
        end

        a_markers: assert property (@(posedge clk) disable iff (reset)
                de |-> (fs == !frame_has_de) && (le == (pix_x == h_active - 1)))
        else begin
                $error("MISMATCH at %0t: fs %b le %b at x %0d y %0d", $time,
                       $sampled(fs), $sampled(le), $sampled(pix_x), $sampled(pix_y));
                ball_video_tb.error_count++;
        end

        a_pixel: assert property (@(posedge clk) disable iff (reset)
                de |-> rgb == expect_rgb)
        else begin
                $error("MISMATCH at %0t: rgb %h, expected %h at x %0d y %0d", $time,
                       $sampled(rgb), $sampled(expect_rgb), $sampled(pix_x), $sampled(pix_y));
                ball_video_tb.error_count++;
        end

        a_hsync_width: assert property (@(posedge clk) disable iff (reset)
                h_rise |-> h_low_len == h_sync)
        else begin
                $error("MISMATCH at %0t: hsync low for %0d cycles", $time, $sampled(h_low_len));
                ball_video_tb.error_count++;
        end

        // each line closed by le and h_total cycles long
        a_line: assert property (@(posedge clk) disable iff (reset)
                h_fall |-> col_cnt == 0 && (!h_armed || h_period == h_total))
        else begin
                $error("MISMATCH at %0t: line period %0d, column %0d at hsync", $time,
                       $sampled(h_period), $sampled(col_cnt));
                ball_video_tb.error_count++;
        end

        a_vsync_width: assert property (@(posedge clk) disable iff (reset)
                v_rise |-> v_low_len == v_sync * h_total)
        else begin
                $error("MISMATCH at %0t: vsync low for %0d cycles", $time, $sampled(v_low_len));
                ball_video_tb.error_count++;
        end

        a_frame: assert property (@(posedge clk) disable iff (reset)
                v_fall |-> row_cnt == v_active && (!v_armed || v_period == h_total * v_total))
        else begin
                $error("MISMATCH at %0t: frame period %0d, %0d rows", $time,
                       $sampled(v_period), $sampled(row_cnt));
                ball_video_tb.error_count++;
        end

endmodule

`default_nettype wire

// ==== bench/ball_video_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_video_tb;

        // 65 frames of 26400 cycles plus margin
        localparam int run_frames     = 65;
        localparam int timeout_cycles = 1_800_000;

        logic        clk = 1'b0;
        logic        reset;
        logic        vsync;
        logic        hsync;
        logic        de;
        logic [23:0] rgb;
        logic        fs;
        logic        le;

        // bumped from the bound checker
        int          error_count = 0;
        int          run_failures = 0;
        int          cycle_count = 0;
        int          frame_count = 0;
        logic        vsync_q = 1'b1;

        ball_video_top u_ball_video_top (
                .clk   (clk),
                .reset (reset),
                .vsync (vsync),
                .hsync (hsync),
                .de    (de),
                .rgb   (rgb),
                .fs    (fs),
                .le    (le)
        );

        bind ball_video_top ball_video_assert u_assert (
                .clk   (clk),
                .reset (reset),
                .vsync (vsync),
                .hsync (hsync),
                .de    (de),
                .rgb   (rgb),
                .fs    (fs),
                .le    (le)
        );

        always #2 clk = ~clk;

        // a frame is done at each vsync falling edge
        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                vsync_q     <= vsync;
                if (vsync_q && !vsync) begin
                        frame_count <= frame_count + 1;
                end
        end

        initial begin
                void'($urandom(30474));
                reset = 1'b1;
                repeat (2) @(negedge clk);
                reset = 1'b0;
                while (frame_count < run_frames && cycle_count < timeout_cycles) begin
                        @(negedge clk);
                end
                if (frame_count < run_frames) begin
                        $display("timeout: only %0d of %0d frames seen after %0d cycles",
                                 frame_count, run_frames, cycle_count);
                        run_failures++;
                end
                if (u_ball_video_top.u_assert.y_flips == 0) begin
                        $display("the ball never bounced off the top edge during the run");
                        run_failures++;
                end
                $display("done: %0d frames, %0d assertion errors, %0d run errors",
                         frame_count, error_count, run_failures);
                if (error_count == 0 && run_failures == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== logic/ball_motion.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_motion (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    vsync,
        output logic signed [video_pkg::coord_width-1:0] ball_x,
        output logic signed [video_pkg::coord_width-1:0] ball_y
);

        import video_pkg::*;

        logic                          vsync_d;
        logic                          frame_start;
        logic signed [coord_width-1:0] dir_x;
        logic signed [coord_width-1:0] dir_y;
        logic                          flip_x;
        logic                          flip_y;

        // falling edge of vsync, one cycle late
        always_ff @(posedge clk) begin
                if (reset) begin
                        vsync_d     <= 1'b1;
                        frame_start <= 1'b0;
                end else begin
                        vsync_d     <= vsync;
                        frame_start <= vsync_d && !vsync;
                end
        end

        // bounce tests on the old position
        always_comb begin
                flip_x = (ball_x < coord_width'(ball_r) && dir_x < 0) ||
                         (ball_x > coord_width'(h_active - ball_r) && dir_x > 0);
                flip_y = (ball_y < coord_width'(ball_r) && dir_y < 0) ||
                         (ball_y > coord_width'(v_active - ball_r) && dir_y > 0);
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        ball_x <= coord_width'(h_active / 2);
                        ball_y <= coord_width'(v_active / 2);
                        dir_x  <= -coord_width'(1);
                        dir_y  <= -coord_width'(1);
                end else if (frame_start) begin
                        ball_x <= ball_x + dir_x;
                        ball_y <= ball_y + dir_y;
                        if (flip_x) begin
                                dir_x <= -dir_x;
                        end
                        if (flip_y) begin
                                dir_y <= -dir_y;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/ball_video_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_video_top (
        input  logic        clk,
        input  logic        reset,
        output logic        vsync,
        output logic        hsync,
        output logic        de,
        output logic [23:0] rgb,
        output logic        fs,
        output logic        le
);

        import video_pkg::*;

        logic                          tg_vsync;
        logic                          tg_hsync;
        logic                          tg_de;
        logic        [x_width-1:0]     tg_x;
        logic        [y_width-1:0]     tg_y;
        logic signed [coord_width-1:0] ball_x;
        logic signed [coord_width-1:0] ball_y;

        video_timing u_video_timing (
                .clk   (clk),
                .reset (reset),
                .vsync (tg_vsync),
                .hsync (tg_hsync),
                .de    (tg_de),
                .x     (tg_x),
                .y     (tg_y)
        );

        ball_motion u_ball_motion (
                .clk    (clk),
                .reset  (reset),
                .vsync  (tg_vsync),
                .ball_x (ball_x),
                .ball_y (ball_y)
        );

        draw_pipeline u_draw_pipeline (
                .clk       (clk),
                .reset     (reset),
                .in_vsync  (tg_vsync),
                .in_hsync  (tg_hsync),
                .in_de     (tg_de),
                .in_x      (tg_x),
                .in_y      (tg_y),
                .ball_x    (ball_x),
                .ball_y    (ball_y),
                .out_vsync (vsync),
                .out_hsync (hsync),
                .out_de    (de),
                .rgb       (rgb),
                .fs        (fs),
                .le        (le)
        );

endmodule

`default_nettype wire

// ==== logic/draw_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module draw_pipeline (
        input  logic                                    clk,
        input  logic                                    reset,
        input  logic                                    in_vsync,
        input  logic                                    in_hsync,
        input  logic                                    in_de,
        input  logic        [video_pkg::x_width-1:0]    in_x,
        input  logic        [video_pkg::y_width-1:0]    in_y,
        input  logic signed [video_pkg::coord_width-1:0] ball_x,
        input  logic signed [video_pkg::coord_width-1:0] ball_y,
        output logic                                    out_vsync,
        output logic                                    out_hsync,
        output logic                                    out_de,
        output logic        [23:0]                      rgb,
        output logic                                    fs,
        output logic                                    le
);

        import video_pkg::*;

        localparam int last = draw_stages - 1;

        // delay line for sync, de and coordinates
        logic               dl_vsync [draw_stages];
        logic               dl_hsync [draw_stages];
        logic               dl_de    [draw_stages];
        logic [x_width-1:0] dl_x     [draw_stages];
        logic [y_width-1:0] dl_y     [draw_stages];

        // painter stages
        logic signed [coord_width-1:0]   st1_dx;
        logic signed [coord_width-1:0]   st1_dy;
        logic        [2*coord_width-1:0] st2_dx2;
        logic        [2*coord_width-1:0] st2_dy2;
        logic        [2*coord_width:0]   st3_r2;
        logic                            st4_ball;
        logic        [23:0]              st5_rgb;
        logic                            on_grid;

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < draw_stages; i++) begin
                                dl_vsync[i] <= 1'b1;
                                dl_hsync[i] <= 1'b1;
                                dl_de[i]    <= 1'b0;
                        end
                end else begin
                        dl_vsync[0] <= in_vsync;
                        dl_hsync[0] <= in_hsync;
                        dl_de[0]    <= in_de;
                        for (int i = 1; i < draw_stages; i++) begin
                                dl_vsync[i] <= dl_vsync[i-1];
                                dl_hsync[i] <= dl_hsync[i-1];
                                dl_de[i]    <= dl_de[i-1];
                        end
                end
        end

        always_ff @(posedge clk) begin
                dl_x[0] <= in_x;
                dl_y[0] <= in_y;
                for (int i = 1; i < draw_stages; i++) begin
                        dl_x[i] <= dl_x[i-1];
                        dl_y[i] <= dl_y[i-1];
                end
        end

        // grid test on coordinates four stages late
        assign on_grid = (dl_x[draw_stages-2][grid_shift-1:0] == '0) ||
                         (dl_y[draw_stages-2][grid_shift-1:0] == '0);

        always_ff @(posedge clk) begin
                st1_dx   <= $signed({1'b0, in_x}) - ball_x;
                st1_dy   <= $signed({1'b0, in_y}) - ball_y;
                st2_dx2  <= st1_dx * st1_dx;
                st2_dy2  <= st1_dy * st1_dy;
                st3_r2   <= {1'b0, st2_dx2} + {1'b0, st2_dy2};
                st4_ball <= (st3_r2 <= (2*coord_width+1)'(ball_r * ball_r));
                // ball wins over grid
                if (st4_ball) begin
                        st5_rgb <= rgb_ball;
                end else if (on_grid) begin
                        st5_rgb <= rgb_grid;
                end else begin
                        st5_rgb <= rgb_bg;
                end
        end

        assign out_vsync = dl_vsync[last];
        assign out_hsync = dl_hsync[last];
        assign out_de    = dl_de[last];
        assign rgb       = st5_rgb;

        // stream markers
        assign fs = dl_de[last] && (dl_x[last] == '0) && (dl_y[last] == '0);
        assign le = dl_de[last] && (dl_x[last] == x_width'(h_active - 1));

endmodule

`default_nettype wire

// ==== logic/video_pkg.sv ====
`default_nettype none

package video_pkg;

        // horizontal raster, in pixels
        localparam int h_active = 160;
        localparam int h_front  = 8;
        localparam int h_sync   = 16;
        localparam int h_back   = 16;
        localparam int h_total  = h_active + h_front + h_sync + h_back;

        // vertical raster, in lines
        localparam int v_active = 120;
        localparam int v_front  = 2;
        localparam int v_sync   = 4;
        localparam int v_back   = 6;
        localparam int v_total  = v_active + v_front + v_sync + v_back;

        // coordinate widths
        localparam int x_width     = 8;
        localparam int y_width     = 8;
        localparam int coord_width = 9;

        // ball radius
        localparam int ball_r = 8;

        // grid every 32 pixels
        localparam int grid_shift = 5;

        // pixel pipeline depth
        localparam int draw_stages = 5;

        // colours, 24 bit rgb
        localparam logic [23:0] rgb_bg   = 24'h00002f;
        localparam logic [23:0] rgb_grid = 24'h0000ff;
        localparam logic [23:0] rgb_ball = 24'hffffff;

endpackage

`default_nettype wire

// ==== logic/video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing (
        input  logic                           clk,
        input  logic                           reset,
        output logic                           vsync,
        output logic                           hsync,
        output logic                           de,
        output logic [video_pkg::x_width-1:0]  x,
        output logic [video_pkg::y_width-1:0]  y
);

        import video_pkg::*;

        logic [x_width-1:0] h_cnt;
        logic [y_width-1:0] v_cnt;
        logic               h_last;
        logic               v_last;
        logic               h_in_sync;
        logic               v_in_sync;
        logic               active;

        assign h_last = (h_cnt == x_width'(h_total - 1));
        assign v_last = (v_cnt == y_width'(v_total - 1));

        // sync window follows the front porch
        always_comb begin
                h_in_sync = (h_cnt >= x_width'(h_active + h_front)) &&
                            (h_cnt <  x_width'(h_active + h_front + h_sync));
                v_in_sync = (v_cnt >= y_width'(v_active + v_front)) &&
                            (v_cnt <  y_width'(v_active + v_front + v_sync));
                active    = (h_cnt < x_width'(h_active)) &&
                            (v_cnt < y_width'(v_active));
        end

        // raster counters
        always_ff @(posedge clk) begin
                if (reset) begin
                        h_cnt <= '0;
                        v_cnt <= '0;
                end else begin
                        if (h_last) begin
                                h_cnt <= '0;
                                if (v_last) begin
                                        v_cnt <= '0;
                                end else begin
                                        v_cnt <= v_cnt + 1'b1;
                                end
                        end else begin
                                h_cnt <= h_cnt + 1'b1;
                        end
                end
        end

        // sync is active low
        always_ff @(posedge clk) begin
                if (reset) begin
                        hsync <= 1'b1;
                        vsync <= 1'b1;
                        de    <= 1'b0;
                end else begin
                        hsync <= !h_in_sync;
                        vsync <= !v_in_sync;
                        de    <= active;
                end
        end

        // coordinates, only valid with de
        always_ff @(posedge clk) begin
                x <= h_cnt;
                y <= v_cnt;
        end

endmodule

`default_nettype wire
